// File: common/ingress_pkg.sv
package ingress_pkg;

    import switch_cfg_pkg::*;

    localparam int              CRC_W      = 16;
    localparam logic [CRC_W-1:0] CRC_POLY  = 16'h1021;
    localparam logic [CRC_W-1:0] CRC_INIT  = 16'hFFFF;
    localparam int              FIFO_DEPTH = LENGTH_MAX;

    typedef logic [CRC_W-1:0] crc_t;

    // Control word carried by the sop beat.
    typedef struct packed {
        logic [DATA_WIDTH-PORT_SEL_W-PRIORITY_W-LENGTH_W-1:0] rsvd;
        port_sel_t dest;
        prio_t     prio;
        length_t   length;
    } ctrl_word_t;

    typedef struct packed {
        crc_t      crc;
        port_sel_t dest;
        prio_t     prio;
        length_t   length;
    } pkt_desc_t;

    // First word emitted on the internal side.
    typedef struct packed {
        logic [DATA_WIDTH-LENGTH_W-CRC_W-PRIORITY_W-1:0] zero;
        length_t length;
        crc_t    crc;
        prio_t   prio;
    } hdr_word_t;

endpackage

// File: common/switch_cfg_pkg.sv
package switch_cfg_pkg;

    localparam int DATA_WIDTH      = 32;
    localparam int PORT_COUNT      = 4;
    localparam int PORT_SEL_W      = $clog2(PORT_COUNT);
    localparam int PRIORITY_LEVELS = 8;
    localparam int PRIORITY_W      = $clog2(PRIORITY_LEVELS);
    localparam int LENGTH_MAX      = 256;

    // One extra bit so that a full LENGTH_MAX packet fits.
    localparam int LENGTH_W        = $clog2(LENGTH_MAX + 1);

    typedef logic [DATA_WIDTH-1:0] data_word_t;
    typedef logic [PORT_SEL_W-1:0] port_sel_t;
    typedef logic [PRIORITY_W-1:0] prio_t;
    typedef logic [LENGTH_W-1:0]   length_t;

endpackage

// File: in_port/in_port.sv
`timescale 1ns/1ns

module in_port #(
    parameter switch_cfg_pkg::port_sel_t PORT_NUM = '0
) (
    input  logic                       arst_n,
    input  logic                       external_clk,
    input  logic                       internal_clk,
    input  logic                       wr_sop,
    input  logic                       wr_eop,
    input  logic                       wr_vld,
    input  switch_cfg_pkg::data_word_t wr_data,
    output logic                       wr_ready,
    input  logic                       ready_in,
    output switch_cfg_pkg::port_sel_t  rx,
    output switch_cfg_pkg::port_sel_t  tx,
    output logic                       vld,
    output switch_cfg_pkg::data_word_t data
);

    import switch_cfg_pkg::*;
    import ingress_pkg::*;

    // ==================================================================
    // External clock domain
    // ==================================================================

    logic      fifo_wr_en;
    logic      crc_clear;
    crc_t      crc_value;
    logic      desc_valid;
    logic      desc_ready;
    pkt_desc_t tx_desc;

    in_wr_controller wr_controller (
        .external_clk (external_clk),
        .arst_n       (arst_n),
        .sop          (wr_sop),
        .eop          (wr_eop),
        .valid        (wr_vld),
        .data_in      (wr_data),
        .wr_en        (fifo_wr_en),
        .crc_clear    (crc_clear),
        .crc_value    (crc_value),
        .desc_valid   (desc_valid),
        .desc         (tx_desc),
        .desc_ready   (desc_ready),
        .ready        (wr_ready)
    );

    crc16_32bit crc (
        .clk       (external_clk),
        .arst_n    (arst_n),
        .clear     (crc_clear),
        .en        (fifo_wr_en),
        .data_in   (wr_data),
        .crc_value (crc_value)
    );

    // ==================================================================
    // Clock domain crossings
    // ==================================================================

    logic       fifo_rd_en;
    logic       fifo_empty;
    data_word_t fifo_rd_data;
    logic       rx_desc_valid;
    logic       rx_ack;
    pkt_desc_t  rx_desc;

    dc_fifo #(
        .T     (data_word_t),
        .DEPTH (FIFO_DEPTH)
    ) fifo (
        .arst_n  (arst_n),
        .wr_clk  (external_clk),
        .wr_en   (fifo_wr_en),
        .wr_data (wr_data),
        .full    (),
        .rd_clk  (internal_clk),
        .rd_en   (fifo_rd_en),
        .rd_data (fifo_rd_data),
        .empty   (fifo_empty)
    );

    cdc_handshake #(
        .T (pkt_desc_t)
    ) desc_cdc (
        .arst_n   (arst_n),
        .tx_clk   (external_clk),
        .rx_clk   (internal_clk),
        .tx_valid (desc_valid),
        .tx_data  (tx_desc),
        .tx_ready (desc_ready),
        .rx_valid (rx_desc_valid),
        .rx_data  (rx_desc),
        .rx_ack   (rx_ack)
    );

    // ==================================================================
    // Internal clock domain
    // ==================================================================

    in_rd_controller rd_controller (
        .internal_clk (internal_clk),
        .arst_n       (arst_n),
        .desc_valid   (rx_desc_valid),
        .desc         (rx_desc),
        .desc_ack     (rx_ack),
        .fifo_empty   (fifo_empty),
        .fifo_data    (fifo_rd_data),
        .fifo_rd_en   (fifo_rd_en),
        .ready_in     (ready_in),
        .rx           (rx),
        .vld          (vld),
        .data         (data)
    );

    assign tx = PORT_NUM;

endmodule

// File: in_port/in_rd_controller.sv
`timescale 1ns/1ns

module in_rd_controller (
    input  logic                       internal_clk,
    input  logic                       arst_n,
    input  logic                       desc_valid,
    input  ingress_pkg::pkt_desc_t     desc,
    output logic                       desc_ack,
    input  logic                       fifo_empty,
    input  switch_cfg_pkg::data_word_t fifo_data,
    output logic                       fifo_rd_en,
    input  logic                       ready_in,
    output switch_cfg_pkg::port_sel_t  rx,
    output logic                       vld,
    output switch_cfg_pkg::data_word_t data
);

    import switch_cfg_pkg::*;
    import ingress_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        DATA
    } state_t;

    state_t    state;
    state_t    state_next;
    length_t   remain;
    hdr_word_t hdr;
    logic      out_sel;
    logic      last_word;

    // The descriptor stays stable until desc_ack, so the header is built directly from it.
    assign hdr.zero   = '0;
    assign hdr.length = desc.length;
    assign hdr.crc    = desc.crc;
    assign hdr.prio   = desc.prio;

    assign out_sel    = (state == HEADER);
    assign vld        = out_sel || ((state == DATA) && !fifo_empty);
    assign data       = out_sel ? data_word_t'(hdr) : fifo_data;
    assign fifo_rd_en = (state == DATA) && !fifo_empty && ready_in;
    assign last_word  = (remain == length_t'(1));
    assign desc_ack   = fifo_rd_en && last_word;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (desc_valid) begin
                    state_next = HEADER;
                end
            end
            HEADER: begin
                if (ready_in) begin
                    state_next = DATA;
                end
            end
            DATA: begin
                if (desc_ack) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge internal_clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= IDLE;
            rx     <= '0;
            remain <= '0;
        end else begin
            state <= state_next;
            if ((state == IDLE) && desc_valid) begin
                rx     <= desc.dest;
                remain <= desc.length;
            end else if (fifo_rd_en) begin
                remain <= remain - 1'b1;
            end
        end
    end

    // A stalled word must not change before the downstream takes it.
    a_hold: assert property (@(posedge internal_clk) disable iff (!arst_n)
        vld && !ready_in |=> vld && $stable(data))
        else $error("output word changed under back-pressure");

endmodule

// File: in_port/in_wr_controller.sv
`timescale 1ns/1ns

module in_wr_controller (
    input  logic                       external_clk,
    input  logic                       arst_n,
    input  logic                       sop,
    input  logic                       eop,
    input  logic                       valid,
    input  switch_cfg_pkg::data_word_t data_in,
    output logic                       wr_en,
    output logic                       crc_clear,
    input  ingress_pkg::crc_t          crc_value,
    output logic                       desc_valid,
    output ingress_pkg::pkt_desc_t     desc,
    input  logic                       desc_ready,
    output logic                       ready
);

    import switch_cfg_pkg::*;
    import ingress_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        RECV,
        LAUNCH
    } state_t;

    state_t     state;
    state_t     state_next;
    ctrl_word_t ctrl_q;
    length_t    word_cnt;
    logic       sop_accept;

    // A new packet is only taken once the previous descriptor has been acknowledged.
    assign ready      = (state == IDLE) && desc_ready;
    assign sop_accept = valid && sop && ready;
    assign crc_clear  = sop_accept;
    assign wr_en      = (state == RECV) && valid;
    assign desc_valid = (state == LAUNCH) && desc_ready;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (sop_accept) begin
                    state_next = RECV;
                end
            end
            RECV: begin
                if (wr_en && eop) begin
                    state_next = LAUNCH;
                end
            end
            LAUNCH: begin
                if (desc_valid) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge external_clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            word_cnt <= '0;
        end else begin
            state <= state_next;
            if (sop_accept) begin
                word_cnt <= '0;
            end else if (wr_en) begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge external_clk) begin
        if (sop_accept) begin
            ctrl_q <= ctrl_word_t'(data_in);
        end
    end

    // The CRC register already holds the last word by the time LAUNCH is reached.
    assign desc.crc    = crc_value;
    assign desc.dest   = ctrl_q.dest;
    assign desc.prio   = ctrl_q.prio;
    assign desc.length = ctrl_q.length;

    a_len_match: assert property (@(posedge external_clk) disable iff (!arst_n)
        wr_en && eop |-> (word_cnt + 1'b1 == ctrl_q.length))
        else $error("eop word count does not match the control word length");

    a_sop_idle: assert property (@(posedge external_clk) disable iff (!arst_n)
        valid && sop |-> ready)
        else $error("sop arrived while a packet is still held");

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the ingress port testbench with Verilator and run it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_in_port \
    -f vlog.f

./obj_dir/Vtb_in_port

// File: src/cdc_handshake.sv
`timescale 1ns/1ns

module cdc_handshake #(
    parameter type T = logic [31:0]
) (
    input  logic arst_n,
    input  logic tx_clk,
    input  logic rx_clk,
    input  logic tx_valid,
    input  T     tx_data,
    output logic tx_ready,
    output logic rx_valid,
    output T     rx_data,
    input  logic rx_ack
);

    logic req_tgl;
    logic ack_tgl;
    logic ack_s1;
    logic ack_s2;
    logic req_s1;
    logic req_s2;
    T     data_q;

    // Sending side. The payload register is only loaded while the channel is free.
    always_ff @(posedge tx_clk or negedge arst_n) begin
        if (!arst_n) begin
            req_tgl <= 1'b0;
            ack_s1  <= 1'b0;
            ack_s2  <= 1'b0;
        end else begin
            if (tx_valid) begin
                req_tgl <= ~req_tgl;
            end
            ack_s1 <= ack_tgl;
            ack_s2 <= ack_s1;
        end
    end

    always_ff @(posedge tx_clk) begin
        if (tx_valid) begin
            data_q <= tx_data;
        end
    end

    assign tx_ready = (req_tgl == ack_s2);

    // Receiving side.
    always_ff @(posedge rx_clk or negedge arst_n) begin
        if (!arst_n) begin
            req_s1  <= 1'b0;
            req_s2  <= 1'b0;
            ack_tgl <= 1'b0;
        end else begin
            req_s1 <= req_tgl;
            req_s2 <= req_s1;
            if (rx_ack) begin
                ack_tgl <= ~ack_tgl;
            end
        end
    end

    assign rx_valid = (req_s2 != ack_tgl);
    assign rx_data  = data_q;

    a_tx_when_ready: assert property (@(posedge tx_clk) disable iff (!arst_n)
        tx_valid |-> tx_ready)
        else $error("tx_valid while a transfer is still in flight");

endmodule

// File: src/crc16_32bit.sv
`timescale 1ns/1ns

module crc16_32bit (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       clear,
    input  logic                       en,
    input  switch_cfg_pkg::data_word_t data_in,
    output ingress_pkg::crc_t          crc_value
);

    import switch_cfg_pkg::*;
    import ingress_pkg::*;

    // Bit-serial CCITT update unrolled over one word, MSB first.
    function automatic crc_t crc_fold(input crc_t crc_in, input data_word_t word);
        crc_t c;
        logic fb;
        c = crc_in;
        for (int i = DATA_WIDTH - 1; i >= 0; i--) begin
            fb = c[CRC_W-1] ^ word[i];
            c  = {c[CRC_W-2:0], 1'b0};
            if (fb) begin
                c = c ^ CRC_POLY;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            crc_value <= CRC_INIT;
        end else if (clear) begin
            crc_value <= CRC_INIT;
        end else if (en) begin
            crc_value <= crc_fold(crc_value, data_in);
        end
    end

endmodule

// File: src/dc_fifo.sv
`timescale 1ns/1ns

module dc_fifo #(
    parameter type T     = switch_cfg_pkg::data_word_t,
    parameter int  DEPTH = ingress_pkg::FIFO_DEPTH
) (
    input  logic arst_n,
    input  logic wr_clk,
    input  logic wr_en,
    input  T     wr_data,
    output logic full,
    input  logic rd_clk,
    input  logic rd_en,
    output T     rd_data,
    output logic empty
);

    localparam int AW = $clog2(DEPTH);

    T mem [DEPTH];

    logic [AW:0] wr_bin;
    logic [AW:0] wr_bin_next;
    logic [AW:0] wr_gray;
    logic [AW:0] rd_bin;
    logic [AW:0] rd_bin_next;
    logic [AW:0] rd_gray;
    logic [AW:0] wr_gray_s1;
    logic [AW:0] wr_gray_s2;
    logic [AW:0] rd_gray_s1;
    logic [AW:0] rd_gray_s2;
    logic        wr_push;
    logic        rd_pop;

    // ==================================================================
    // Write side
    // ==================================================================

    assign wr_push     = wr_en && !full;
    assign wr_bin_next = wr_bin + {{AW{1'b0}}, wr_push};

    // Full when the pointers differ only in the two top Gray bits.
    assign full = (wr_gray == {~rd_gray_s2[AW:AW-1], rd_gray_s2[AW-2:0]});

    always_ff @(posedge wr_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            wr_bin     <= wr_bin_next;
            wr_gray    <= wr_bin_next ^ (wr_bin_next >> 1);
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_push) begin
            mem[wr_bin[AW-1:0]] <= wr_data;
        end
    end

    // ==================================================================
    // Read side
    // ==================================================================

    assign rd_pop      = rd_en && !empty;
    assign rd_bin_next = rd_bin + {{AW{1'b0}}, rd_pop};
    assign empty       = (rd_gray == wr_gray_s2);
    assign rd_data     = mem[rd_bin[AW-1:0]];

    always_ff @(posedge rd_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            rd_bin     <= rd_bin_next;
            rd_gray    <= rd_bin_next ^ (rd_bin_next >> 1);
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
        end
    end

    a_no_overflow: assert property (@(posedge wr_clk) disable iff (!arst_n) wr_en |-> !full)
        else $error("write into a full FIFO");

    a_no_underflow: assert property (@(posedge rd_clk) disable iff (!arst_n) rd_en |-> !empty)
        else $error("read from an empty FIFO");

endmodule

// File: test/tb_in_port_tasks.svh
`ifndef TB_IN_PORT_TASKS_SVH
`define TB_IN_PORT_TASKS_SVH

// ======================================================================
// Compare tasks
// ======================================================================

task automatic compare_word(input string name, input data_word_t got, input data_word_t exp);
    if (got !== exp) begin
        $display("ERROR %s: got 0x%08h expected 0x%08h", name, got, exp);
        fail_run($sformatf("mismatch on %s", name));
    end
endtask

task automatic compare_port(input string name, input port_sel_t got, input port_sel_t exp);
    if (got !== exp) begin
        $display("ERROR %s: got 0x%h expected 0x%h", name, got, exp);
        fail_run($sformatf("mismatch on %s", name));
    end
endtask

task automatic compare_hdr(input string name, input hdr_word_t got, input hdr_word_t exp);
    if (got !== exp) begin
        $display("ERROR %s: got 0x%08h expected 0x%08h", name,
                 data_word_t'(got), data_word_t'(exp));
        fail_run($sformatf("mismatch on %s", name));
    end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("ERROR %s: got 0x%h expected 0x%h", name, got, exp);
        fail_run($sformatf("mismatch on %s", name));
    end
endtask

// Reference CCITT CRC. Each word is taken MSB first and each bit enters at the top
// before the shift.
function automatic crc_t ref_crc(input data_word_t words[$]);
    logic [15:0] crc;
    crc = CRC_INIT;
    foreach (words[w]) begin
        for (int b = DATA_WIDTH - 1; b >= 0; b--) begin
            crc = crc ^ {words[w][b], 15'b0};
            if (crc[15]) begin
                crc = {crc[14:0], 1'b0} ^ CRC_POLY;
            end else begin
                crc = {crc[14:0], 1'b0};
            end
        end
    end
    return crc;
endfunction

// ======================================================================
// Waits
// ======================================================================

task automatic wait_wr_ready();
    int cycles;
    cycles = 0;
    while (wr_ready !== 1'b1) begin
        if (cycles == TIMEOUT_CYCLES) begin
            fail_run("timeout waiting for wr_ready to return high");
        end
        @(posedge external_clk);
        #DRIVE_DELAY;
        cycles++;
    end
endtask

// The port must not accept a new packet while words of this one are still pending.
task automatic wait_out_words(input int n);
    int cycles;
    cycles = 0;
    while (out_q.size() < n) begin
        if (wr_ready === 1'b1) begin
            fail_run("wr_ready rose before the last data word was taken");
        end
        if (cycles == TIMEOUT_CYCLES) begin
            fail_run("timeout waiting for output words");
        end
        @(posedge internal_clk);
        cycles++;
    end
endtask

// ======================================================================
// Packet driver and checker
// ======================================================================

task automatic send_packet(input port_sel_t dest, input prio_t prio, input length_t len);
    logic [31:0] rnd;
    pkt_q.delete();
    for (int i = 0; i < int'(len); i++) begin
        pkt_q.push_back(data_word_t'($urandom()));
    end
    wait_wr_ready();
    // The upper bits of the control word are ignored, so they carry noise.
    rnd     = $urandom();
    wr_vld  = 1'b1;
    wr_sop  = 1'b1;
    wr_data = {rnd[17:0], dest, prio, len};
    @(posedge external_clk);
    #DRIVE_DELAY;
    compare_bit("wr_ready", wr_ready, 1'b0);
    wr_sop = 1'b0;
    foreach (pkt_q[i]) begin
        wr_data = pkt_q[i];
        wr_eop  = (i == pkt_q.size() - 1);
        @(posedge external_clk);
        #DRIVE_DELAY;
    end
    wr_vld  = 1'b0;
    wr_eop  = 1'b0;
    wr_data = '0;
endtask

task automatic check_packet(input port_sel_t dest, input prio_t prio, input length_t len);
    hdr_word_t exp_hdr;
    int        n;
    n = int'(len) + 1;
    wait_out_words(n);
    wait_wr_ready();
    if (out_q.size() != n) begin
        fail_run("more output words than the packet holds");
    end
    exp_hdr = hdr_word_t'({4'h0, len, ref_crc(pkt_q), prio});
    compare_hdr("header", hdr_word_t'(out_q.pop_front()), exp_hdr);
    compare_port("rx", rx_q.pop_front(), dest);
    foreach (pkt_q[i]) begin
        compare_word("data", out_q.pop_front(), pkt_q[i]);
        compare_port("rx", rx_q.pop_front(), dest);
    end
endtask

`endif

// File: test/tb_in_port.sv
`timescale 1ns/1ns

module tb_in_port;

    import switch_cfg_pkg::*;
    import ingress_pkg::*;

    localparam logic [31:0] SEED           = 32'hfa67_1120;
    localparam int          CLK_PERIOD     = 40;
    localparam int          EXT_CLK_OFFSET = 13;
    localparam int          RESET_CYCLES   = 10;
    localparam int          DRIVE_DELAY    = 2;
    localparam int          TIMEOUT_CYCLES = 2000;
    localparam port_sel_t   PORT_NUM       = port_sel_t'(3);

    logic       arst_n;
    logic       external_clk;
    logic       internal_clk;
    logic       wr_sop;
    logic       wr_eop;
    logic       wr_vld;
    data_word_t wr_data;
    logic       wr_ready;
    logic       ready_in;
    port_sel_t  rx;
    port_sel_t  tx;
    logic       vld;
    data_word_t data;

    // Words and destinations seen downstream, and the payload of the packet in flight.
    data_word_t out_q[$];
    port_sel_t  rx_q[$];
    data_word_t pkt_q[$];
    logic       ready_random;

    in_port #(
        .PORT_NUM (PORT_NUM)
    ) dut_i (
        .arst_n       (arst_n),
        .external_clk (external_clk),
        .internal_clk (internal_clk),
        .wr_sop       (wr_sop),
        .wr_eop       (wr_eop),
        .wr_vld       (wr_vld),
        .wr_data      (wr_data),
        .wr_ready     (wr_ready),
        .ready_in     (ready_in),
        .rx           (rx),
        .tx           (tx),
        .vld          (vld),
        .data         (data)
    );

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    `include "tb_in_port_tasks.svh"

    // ==================================================================
    // Clocks, downstream ready and output monitor
    // ==================================================================

    initial begin
        internal_clk = 1'b0;
        forever #(CLK_PERIOD / 2) internal_clk = ~internal_clk;
    end

    initial begin
        external_clk = 1'b0;
        #EXT_CLK_OFFSET;
        forever #(CLK_PERIOD / 2) external_clk = ~external_clk;
    end

    initial begin
        logic [31:0] rnd;
        ready_in = 1'b0;
        forever begin
            @(posedge internal_clk);
            #DRIVE_DELAY;
            if (ready_random) begin
                rnd      = $urandom();
                ready_in = rnd[0];
            end else begin
                ready_in = 1'b1;
            end
        end
    end

    // Sampled mid-cycle, where vld, data and ready_in are settled for the next edge.
    initial begin
        forever begin
            @(negedge internal_clk);
            if (arst_n && vld && ready_in) begin
                out_q.push_back(data);
                rx_q.push_back(rx);
            end
        end
    end

    // ==================================================================
    // Directed tests
    // ==================================================================

    task automatic test_reset_state();
        compare_bit("wr_ready", wr_ready, 1'b1);
        compare_bit("vld", vld, 1'b0);
        compare_port("tx", tx, PORT_NUM);
        compare_port("rx", rx, port_sel_t'(0));
    endtask

    task automatic test_single_word();
        ready_random = 1'b0;
        send_packet(port_sel_t'(2), prio_t'(5), length_t'(1));
        check_packet(port_sel_t'(2), prio_t'(5), length_t'(1));
    endtask

    task automatic test_full_length();
        ready_random = 1'b0;
        send_packet(port_sel_t'(1), prio_t'(3), length_t'(LENGTH_MAX));
        check_packet(port_sel_t'(1), prio_t'(3), length_t'(LENGTH_MAX));
    endtask

    task automatic test_random_ready();
        ready_random = 1'b1;
        send_packet(port_sel_t'(0), prio_t'(7), length_t'(64));
        check_packet(port_sel_t'(0), prio_t'(7), length_t'(64));
        send_packet(port_sel_t'(3), prio_t'(1), length_t'(LENGTH_MAX));
        check_packet(port_sel_t'(3), prio_t'(1), length_t'(LENGTH_MAX));
    endtask

    task automatic test_back_to_back();
        logic [31:0] rnd;
        length_t     len;
        prio_t       prio;
        ready_random = 1'b1;
        for (int d = 0; d < PORT_COUNT; d++) begin
            rnd  = $urandom();
            len  = length_t'(rnd[4:0]) + length_t'(1);
            prio = rnd[10:8];
            send_packet(port_sel_t'(d), prio, len);
            check_packet(port_sel_t'(d), prio, len);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        arst_n       = 1'b0;
        wr_sop       = 1'b0;
        wr_eop       = 1'b0;
        wr_vld       = 1'b0;
        wr_data      = '0;
        ready_random = 1'b0;
        repeat (RESET_CYCLES) @(posedge external_clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        @(posedge external_clk);
        #DRIVE_DELAY;

        test_reset_state();
        test_single_word();
        test_full_length();
        test_random_ready();
        test_back_to_back();

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+test
common/switch_cfg_pkg.sv
common/ingress_pkg.sv
src/crc16_32bit.sv
src/dc_fifo.sv
src/cdc_handshake.sv
in_port/in_wr_controller.sv
in_port/in_rd_controller.sv
in_port/in_port.sv
test/tb_in_port.sv
